//--- rtl/menu_pkg.sv
// Menu package for the coffee machine front panel
// Menu states, selection encodings and timing defaults

package menu_pkg;

    // Menu states, reference numbering kept
    typedef enum logic [3:0] {
        ST_SPLASH             = 4'd0,
        ST_CHECK_ERRORS       = 4'd1,
        ST_COFFEE_SELECT      = 4'd2,
        ST_DRINK_SELECT       = 4'd3,
        ST_SIZE_SELECT        = 4'd4,
        ST_CONFIRM            = 4'd5,
        ST_BREWING            = 4'd6,
        ST_COMPLETE           = 4'd7,
        ST_INSUFFICIENT       = 4'd10,
        ST_ABORT_CONFIRM      = 4'd11,
        ST_MAINTENANCE        = 4'd12,
        ST_MAINT_OPTIONS      = 4'd13,
        ST_MAINT_VIEW_ERRORS  = 4'd14,
        ST_MAINT_MANUAL_CHECK = 4'd15
    } menu_state_e;

    // Hidden maintenance options
    typedef enum logic [1:0] {
        MAINT_VIEW_ERRORS,
        MAINT_MANUAL_CHECK,
        MAINT_SERVICE_TIME,
        MAINT_EXIT
    } maint_opt_e;

    typedef enum logic [2:0] {
        DRINK_BLACK,
        DRINK_CREAM,
        DRINK_LATTE,
        DRINK_MOCHA,
        DRINK_HOT_CHOC
    } drink_e;

    typedef enum logic [1:0] {
        SIZE_8OZ,
        SIZE_12OZ,
        SIZE_16OZ
    } size_e;

    // Cursor wrap limits
    localparam int NUM_COFFEE_BINS   = 2;
    localparam int NUM_DRINKS        = 5;
    localparam int NUM_SIZES         = 3;
    localparam int NUM_MAINT_OPTIONS = 4;
    localparam int BIN_W             = 3;

    // Button indices into the debounced level vector
    localparam int NUM_BUTTONS = 4;
    localparam int BTN_CANCEL  = 0;
    localparam int BTN_LEFT    = 1;
    localparam int BTN_RIGHT   = 2;
    localparam int BTN_SELECT  = 3;

    // Board defaults at 50 MHz
    localparam int unsigned DEBOUNCE_CYCLES      = 1_000_000;
    localparam int unsigned COMBO_HOLD_CYCLES    = 2_500_000;
    localparam int unsigned INSUFFICIENT_TIMEOUT = 500_000_000;

endpackage

//--- rtl/button_event_if.sv
// Button event bundle
// One-cycle press strobes and the maintenance combo strobe

`timescale 1ns/1ns

interface button_event_if;

    logic cancel_pressed;
    logic left_pressed;
    logic right_pressed;
    logic select_pressed;
    // Combo held long enough, repeats while held
    logic combo_active;

    modport source (
        output cancel_pressed, left_pressed, right_pressed, select_pressed, combo_active
    );

    modport sink (
        input cancel_pressed, left_pressed, right_pressed, select_pressed, combo_active
    );

endinterface

//--- rtl/debounce_filter.sv
// Debounce filter for one raw button
// Level follows the input once it has disagreed long enough

`timescale 1ns/1ns

module debounce_filter #(
    parameter int unsigned STABLE_CYCLES = menu_pkg::DEBOUNCE_CYCLES
) (
    input  logic clk,
    input  logic rst_n,
    input  logic raw,
    output logic level
);

    // Counter only needs to reach STABLE_CYCLES-1
    localparam int CNT_W = (STABLE_CYCLES > 1) ? $clog2(STABLE_CYCLES) : 1;

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt   <= '0;
            level <= 1'b0;
        end else if (raw == level) begin
            // Bounce back to old value restarts the count
            cnt <= '0;
        end else if (cnt >= CNT_W'(STABLE_CYCLES - 1)) begin
            level <= raw;
            cnt   <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

//--- rtl/button_events.sv
// Button event generator
// Rising-edge press pulses and the maintenance combo hold timer

`timescale 1ns/1ns

module button_events #(
    parameter int unsigned HOLD_CYCLES = menu_pkg::COMBO_HOLD_CYCLES
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [menu_pkg::NUM_BUTTONS-1:0] levels,
    button_event_if.source                   events
);

    import menu_pkg::*;

    localparam int HOLD_W = (HOLD_CYCLES > 1) ? $clog2(HOLD_CYCLES) : 1;

    logic [NUM_BUTTONS-1:0] levels_prev;
    logic [NUM_BUTTONS-1:0] pressed;
    logic                   combo_held;
    logic [HOLD_W-1:0]      hold_cnt;
    logic                   combo_strobe;

    //============================================================
    // Edge detection
    //============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            levels_prev <= '0;
        end else begin
            levels_prev <= levels;
        end
    end

    assign pressed = levels & ~levels_prev;

    assign events.cancel_pressed = pressed[BTN_CANCEL];
    assign events.left_pressed   = pressed[BTN_LEFT];
    assign events.right_pressed  = pressed[BTN_RIGHT];
    assign events.select_pressed = pressed[BTN_SELECT];

    //============================================================
    // Combo hold timer
    //============================================================
    // Either arrow together with select
    assign combo_held = (levels[BTN_LEFT] | levels[BTN_RIGHT]) & levels[BTN_SELECT];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hold_cnt     <= '0;
            combo_strobe <= 1'b0;
        end else if (!combo_held) begin
            hold_cnt     <= '0;
            combo_strobe <= 1'b0;
        end else if (hold_cnt >= HOLD_W'(HOLD_CYCLES - 1)) begin
            // Restart so the strobe repeats while held
            hold_cnt     <= '0;
            combo_strobe <= 1'b1;
        end else begin
            hold_cnt     <= hold_cnt + 1'b1;
            combo_strobe <= 1'b0;
        end
    end

    assign events.combo_active = combo_strobe;

endmodule

//--- rtl/selection_cursors.sv
// Selection cursors for bin, drink, size and maintenance option
// Each cursor wraps and moves only while its own menu is shown

`timescale 1ns/1ns

module selection_cursors (
    input  logic                       clk,
    input  logic                       rst_n,
    button_event_if.sink               events,
    input  menu_pkg::menu_state_e      state,
    output logic [menu_pkg::BIN_W-1:0] coffee_bin,
    output menu_pkg::drink_e           drink,
    output menu_pkg::size_e            size,
    output menu_pkg::maint_opt_e       maint_option
);

    import menu_pkg::*;

    logic [2:0] bin_next;
    logic [2:0] drink_next;
    logic [2:0] size_next;
    logic [2:0] maint_next;

    // Left wraps 0 to limit-1, right wraps limit-1 to 0
    function automatic logic [2:0] step(input logic [2:0] cur, input logic [2:0] limit,
                                        input logic dec, input logic inc);
        logic [2:0] nxt;
        nxt = cur;
        if (dec) begin
            nxt = (cur == 3'd0) ? limit - 3'd1 : cur - 3'd1;
        end else if (inc) begin
            nxt = (cur >= limit - 3'd1) ? 3'd0 : cur + 3'd1;
        end
        return nxt;
    endfunction

    always_comb begin
        bin_next   = step(coffee_bin, 3'(NUM_COFFEE_BINS),
                          events.left_pressed && state == ST_COFFEE_SELECT,
                          events.right_pressed && state == ST_COFFEE_SELECT);
        drink_next = step(3'(drink), 3'(NUM_DRINKS),
                          events.left_pressed && state == ST_DRINK_SELECT,
                          events.right_pressed && state == ST_DRINK_SELECT);
        size_next  = step({1'b0, size}, 3'(NUM_SIZES),
                          events.left_pressed && state == ST_SIZE_SELECT,
                          events.right_pressed && state == ST_SIZE_SELECT);
        maint_next = step({1'b0, maint_option}, 3'(NUM_MAINT_OPTIONS),
                          events.left_pressed && state == ST_MAINT_OPTIONS,
                          events.right_pressed && state == ST_MAINT_OPTIONS);
    end

    //============================================================
    // Cursor registers
    //============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            coffee_bin   <= '0;
            drink        <= DRINK_BLACK;
            // 12 oz is the default cup
            size         <= SIZE_12OZ;
            maint_option <= MAINT_VIEW_ERRORS;
        end else begin
            coffee_bin   <= bin_next;
            drink        <= drink_e'(drink_next);
            size         <= size_e'(size_next[1:0]);
            maint_option <= maint_opt_e'(maint_next[1:0]);
        end
    end

endmodule

//--- rtl/menu_fsm.sv
// Menu state machine for the coffee machine front panel
// Brew flow, insufficient-resource screen, abort and hidden maintenance menu
// Control outputs are registered one-cycle strobes and levels

`timescale 1ns/1ns

module menu_fsm #(
    parameter int unsigned TIMEOUT_CYCLES = menu_pkg::INSUFFICIENT_TIMEOUT
) (
    input  logic                   clk,
    input  logic                   rst_n,
    button_event_if.sink           events,
    input  menu_pkg::maint_opt_e   maint_option,
    input  logic                   error_present,
    input  logic [3:0]             error_count,
    input  logic [3:0]             warning_count,
    input  logic                   pressure_ready,
    input  logic                   can_make_coffee,
    input  logic                   recipe_valid,
    input  logic                   brewing_active,
    output menu_pkg::menu_state_e  state,
    output logic                   start_brewing_cmd,
    output logic                   maintenance_mode,
    output logic                   manual_check_requested,
    output logic                   display_refresh
);

    import menu_pkg::*;

    localparam int TMR_W = (TIMEOUT_CYCLES > 1) ? $clog2(TIMEOUT_CYCLES) : 1;

    menu_state_e      next_state;
    menu_state_e      return_state;
    logic [TMR_W-1:0] insuf_timer;
    logic             brew_started;
    logic             state_changed;
    logic             in_brew_flow;
    logic             in_maint;

    // Combo may only interrupt these menus
    assign in_brew_flow = state inside {ST_SPLASH, ST_CHECK_ERRORS, ST_COFFEE_SELECT,
                                        ST_DRINK_SELECT, ST_SIZE_SELECT, ST_CONFIRM};
    assign in_maint     = state inside {ST_MAINTENANCE, ST_MAINT_OPTIONS,
                                        ST_MAINT_VIEW_ERRORS, ST_MAINT_MANUAL_CHECK};

    //============================================================
    // Insufficient timer, return memory, brew guard
    //============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            insuf_timer  <= '0;
            return_state <= ST_CONFIRM;
            brew_started <= 1'b0;
        end else begin
            // Timer only runs on the insufficient screen
            insuf_timer <= (state == ST_INSUFFICIENT) ? insuf_timer + 1'b1 : '0;
            // Remember where we came from
            if (state != ST_INSUFFICIENT && next_state == ST_INSUFFICIENT) begin
                return_state <= state;
            end
            // Machine must report brewing before completion counts
            if (state != ST_BREWING) begin
                brew_started <= 1'b0;
            end else if (brewing_active) begin
                brew_started <= 1'b1;
            end
        end
    end

    //============================================================
    // Next state
    //============================================================
    always_comb begin
        next_state = state;
        case (state)
            ST_SPLASH: begin
                if (events.select_pressed && !error_present) next_state = ST_CHECK_ERRORS;
            end
            ST_CHECK_ERRORS: begin
                // Critical errors block, warnings need acknowledge
                if (error_present && error_count != 4'd0) begin
                    next_state = ST_CHECK_ERRORS;
                end else if (warning_count != 4'd0 && events.select_pressed) begin
                    next_state = ST_COFFEE_SELECT;
                end else if (!error_present && warning_count == 4'd0 &&
                             pressure_ready && can_make_coffee) begin
                    next_state = ST_COFFEE_SELECT;
                end else if (events.cancel_pressed) begin
                    next_state = ST_SPLASH;
                end
            end
            ST_COFFEE_SELECT: begin
                if (events.select_pressed)      next_state = ST_DRINK_SELECT;
                else if (events.cancel_pressed) next_state = ST_SPLASH;
            end
            ST_DRINK_SELECT: begin
                if (events.select_pressed)      next_state = ST_SIZE_SELECT;
                else if (events.cancel_pressed) next_state = ST_COFFEE_SELECT;
            end
            ST_SIZE_SELECT: begin
                if (events.select_pressed)      next_state = ST_CONFIRM;
                else if (events.cancel_pressed) next_state = ST_DRINK_SELECT;
            end
            ST_CONFIRM: begin
                if (events.select_pressed) begin
                    next_state = recipe_valid ? ST_BREWING : ST_INSUFFICIENT;
                end else if (events.cancel_pressed) begin
                    next_state = ST_SIZE_SELECT;
                end
            end
            ST_INSUFFICIENT: begin
                if (insuf_timer >= TMR_W'(TIMEOUT_CYCLES - 1) || events.cancel_pressed) begin
                    next_state = return_state;
                end
            end
            ST_BREWING: begin
                // Only abort request or real completion
                if (events.cancel_pressed)              next_state = ST_ABORT_CONFIRM;
                else if (!brewing_active && brew_started) next_state = ST_COMPLETE;
            end
            ST_ABORT_CONFIRM: begin
                if (events.select_pressed)      next_state = ST_SPLASH;
                else if (events.cancel_pressed) next_state = ST_BREWING;
            end
            ST_COMPLETE: begin
                // Any button dismisses
                if (events.select_pressed || events.cancel_pressed ||
                    events.left_pressed || events.right_pressed) begin
                    next_state = ST_SPLASH;
                end
            end
            ST_MAINTENANCE: next_state = ST_MAINT_OPTIONS;
            ST_MAINT_OPTIONS: begin
                if (events.select_pressed) begin
                    case (maint_option)
                        MAINT_VIEW_ERRORS:  next_state = ST_MAINT_VIEW_ERRORS;
                        MAINT_MANUAL_CHECK: next_state = ST_MAINT_MANUAL_CHECK;
                        // Service time shares the error view screen
                        MAINT_SERVICE_TIME: next_state = ST_MAINT_VIEW_ERRORS;
                        default:            next_state = ST_SPLASH;
                    endcase
                end else if (events.cancel_pressed) begin
                    next_state = ST_SPLASH;
                end
            end
            ST_MAINT_VIEW_ERRORS: begin
                if (events.cancel_pressed) next_state = ST_MAINT_OPTIONS;
            end
            ST_MAINT_MANUAL_CHECK: begin
                if (events.select_pressed || events.cancel_pressed) next_state = ST_MAINT_OPTIONS;
            end
            default: next_state = ST_SPLASH;
        endcase
        // Combo wins over everything in the brew flow
        if (events.combo_active && in_brew_flow) next_state = ST_MAINTENANCE;
    end

    //============================================================
    // State and control registers
    //============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state                  <= ST_SPLASH;
            state_changed          <= 1'b0;
            start_brewing_cmd      <= 1'b0;
            maintenance_mode       <= 1'b0;
            manual_check_requested <= 1'b0;
            display_refresh        <= 1'b0;
        end else begin
            state                  <= next_state;
            state_changed          <= (next_state != state);
            // Abort-confirm return to brewing does not restart the brew
            start_brewing_cmd      <= (state == ST_CONFIRM) && (next_state == ST_BREWING);
            maintenance_mode       <= in_maint;
            manual_check_requested <= (state == ST_MAINT_MANUAL_CHECK) && events.select_pressed;
            display_refresh        <= state_changed;
        end
    end

endmodule

//--- rtl/menu_navigator.sv
// Coffee machine front panel navigator
// Debounces four buttons, forms press events and runs the menu state machine

`timescale 1ns/1ns

module menu_navigator #(
    parameter int unsigned DEBOUNCE_CYCLES      = menu_pkg::DEBOUNCE_CYCLES,
    parameter int unsigned COMBO_HOLD_CYCLES    = menu_pkg::COMBO_HOLD_CYCLES,
    parameter int unsigned INSUFFICIENT_TIMEOUT = menu_pkg::INSUFFICIENT_TIMEOUT
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       btn_cancel,
    input  logic                       btn_left,
    input  logic                       btn_right,
    input  logic                       btn_select,
    input  logic                       error_present,
    input  logic [3:0]                 error_count,
    input  logic [3:0]                 warning_count,
    input  logic                       pressure_ready,
    input  logic                       can_make_coffee,
    input  logic                       recipe_valid,
    input  logic                       brewing_active,
    output menu_pkg::menu_state_e      state,
    output logic [menu_pkg::BIN_W-1:0] coffee_bin,
    output menu_pkg::drink_e           drink,
    output menu_pkg::size_e            size,
    output menu_pkg::maint_opt_e       maint_option,
    output logic                       start_brewing_cmd,
    output logic                       maintenance_mode,
    output logic                       manual_check_requested,
    output logic                       display_refresh
);

    import menu_pkg::*;

    logic [NUM_BUTTONS-1:0] raw_buttons;
    logic [NUM_BUTTONS-1:0] levels;

    button_event_if events ();

    // Pack raw buttons by index
    assign raw_buttons[BTN_CANCEL] = btn_cancel;
    assign raw_buttons[BTN_LEFT]   = btn_left;
    assign raw_buttons[BTN_RIGHT]  = btn_right;
    assign raw_buttons[BTN_SELECT] = btn_select;

    // One filter per button
    for (genvar i = 0; i < NUM_BUTTONS; i++) begin : g_debounce
        debounce_filter #(.STABLE_CYCLES(DEBOUNCE_CYCLES)) u_filter (
            .clk(clk), .rst_n(rst_n), .raw(raw_buttons[i]), .level(levels[i])
        );
    end

    button_events #(.HOLD_CYCLES(COMBO_HOLD_CYCLES)) u_events (
        .clk(clk), .rst_n(rst_n), .levels(levels), .events(events.source)
    );

    selection_cursors u_cursors (
        .clk(clk), .rst_n(rst_n), .events(events.sink), .state(state),
        .coffee_bin(coffee_bin), .drink(drink), .size(size), .maint_option(maint_option)
    );

    menu_fsm #(.TIMEOUT_CYCLES(INSUFFICIENT_TIMEOUT)) u_fsm (
        .clk(clk), .rst_n(rst_n), .events(events.sink), .maint_option(maint_option),
        .error_present(error_present), .error_count(error_count),
        .warning_count(warning_count), .pressure_ready(pressure_ready),
        .can_make_coffee(can_make_coffee), .recipe_valid(recipe_valid),
        .brewing_active(brewing_active), .state(state),
        .start_brewing_cmd(start_brewing_cmd), .maintenance_mode(maintenance_mode),
        .manual_check_requested(manual_check_requested),
        .display_refresh(display_refresh)
    );

endmodule

//--- bench/tb_menu_tasks.svh
// Testbench tasks for the menu navigator
// Button presses, combo hold and bounded waits on the DUT

`ifndef TB_MENU_TASKS_SVH
`define TB_MENU_TASKS_SVH

// Random idle time between presses
task automatic idle_gap();
    int gap;
    gap = 1 + ($unsigned($random(seed)) % 4);
    repeat (gap) @(negedge clk);
endtask

// Hold one button past the debounce time then release and settle
task automatic press_button(input int idx);
    @(negedge clk);
    btn[idx] = 1'b1;
    repeat (SETTLE_CYCLES) @(negedge clk);
    btn[idx] = 1'b0;
    repeat (SETTLE_CYCLES) @(negedge clk);
    idle_gap();
endtask

// Arrow plus select held until the maintenance flag comes up
task automatic hold_combo(input int arrow);
    int waited;
    waited = 0;
    @(negedge clk);
    btn[arrow]      = 1'b1;
    btn[BTN_SELECT] = 1'b1;
    while (!maintenance_mode && waited < COMBO_LIMIT) begin
        @(negedge clk);
        waited++;
    end
    btn[arrow]      = 1'b0;
    btn[BTN_SELECT] = 1'b0;
    if (!maintenance_mode) begin
        record_failure("Maintenance mode never came up while the combo was held");
    end
    repeat (SETTLE_CYCLES) @(negedge clk);
endtask

// Bounded wait for a menu state
task automatic wait_state(input menu_state_e target, input int limit);
    int waited;
    waited = 0;
    while (state != target && waited < limit) begin
        @(negedge clk);
        waited++;
    end
    if (state != target) begin
        record_failure($sformatf("Timed out after %0d cycles waiting for state %s",
                                 limit, target.name()));
    end
endtask

// Splash through the whole selection flow up to confirm
task automatic walk_to_confirm();
    repeat (4) press_button(BTN_SELECT);
    wait_state(ST_CONFIRM, STATE_LIMIT);
endtask

`endif

//--- bench/tb_menu_navigator.sv
// Testbench for the coffee machine menu navigator
// Walks the brew flow, insufficient screen, abort and maintenance menu

`timescale 1ns/1ns

module tb_menu_navigator;

    import menu_pkg::*;

    // Shrunk timing for simulation
    localparam int DEB_CYCLES    = 4;
    localparam int HOLD_CYCLES   = 16;
    localparam int INSUF_TO      = 40;
    localparam int SETTLE_CYCLES = DEB_CYCLES + 2;
    localparam int COMBO_LIMIT   = DEB_CYCLES + 2 * HOLD_CYCLES + 20;
    localparam int STATE_LIMIT   = 100;

    logic                   clk;
    logic                   rst_n;
    logic [NUM_BUTTONS-1:0] btn;
    logic                   error_present;
    logic [3:0]             error_count;
    logic [3:0]             warning_count;
    logic                   pressure_ready;
    logic                   can_make_coffee;
    logic                   recipe_valid;
    logic                   brewing_active;
    menu_state_e            state;
    logic [BIN_W-1:0]       coffee_bin;
    drink_e                 drink;
    size_e                  size;
    maint_opt_e             maint_option;
    logic                   start_brewing_cmd;
    logic                   maintenance_mode;
    logic                   manual_check_requested;
    logic                   display_refresh;

    integer seed;
    int     errors;
    int     checks;
    int     start_pulses;
    int     check_pulses;
    int     insuf_run;
    int     insuf_dwell;
    int     exp_drink;
    int     pulses_before;
    bit     seen_check;

    menu_navigator #(
        .DEBOUNCE_CYCLES(DEB_CYCLES),
        .COMBO_HOLD_CYCLES(HOLD_CYCLES),
        .INSUFFICIENT_TIMEOUT(INSUF_TO)
    ) uut (
        .clk(clk), .rst_n(rst_n),
        .btn_cancel(btn[BTN_CANCEL]), .btn_left(btn[BTN_LEFT]),
        .btn_right(btn[BTN_RIGHT]), .btn_select(btn[BTN_SELECT]),
        .error_present(error_present), .error_count(error_count),
        .warning_count(warning_count), .pressure_ready(pressure_ready),
        .can_make_coffee(can_make_coffee), .recipe_valid(recipe_valid),
        .brewing_active(brewing_active), .state(state), .coffee_bin(coffee_bin),
        .drink(drink), .size(size), .maint_option(maint_option),
        .start_brewing_cmd(start_brewing_cmd), .maintenance_mode(maintenance_mode),
        .manual_check_requested(manual_check_requested),
        .display_refresh(display_refresh)
    );

    `include "tb_menu_tasks.svh"

    // 8 ns period
    always #4 clk = ~clk;

    function automatic bit is_maint_screen(input menu_state_e s);
        return s inside {ST_MAINTENANCE, ST_MAINT_OPTIONS,
                         ST_MAINT_VIEW_ERRORS, ST_MAINT_MANUAL_CHECK};
    endfunction

    task automatic expect_eq(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("ERR %s: got %h expected %h", what, got, exp);
        end
    endtask

    task automatic record_failure(input string why);
        errors++;
        $display("%s", why);
    endtask

    //============================================================
    // Protocol assertions
    //============================================================
    // Refresh trails each state change by two cycles
    refresh_after_change: assert property (@(posedge clk) disable iff (!rst_n)
        display_refresh == ($past(state, 1) != $past(state, 2)))
        else begin
            errors++;
            $display("ERR display_refresh: got %h expected %h",
                     $sampled(display_refresh), !$sampled(display_refresh));
        end

    // Start pulse only in the first brewing cycle after confirm
    start_on_brew_entry: assert property (@(posedge clk) disable iff (!rst_n)
        start_brewing_cmd == (state == ST_BREWING && $past(state) == ST_CONFIRM))
        else begin
            errors++;
            $display("ERR start_brewing_cmd: got %h state %h",
                     $sampled(start_brewing_cmd), $sampled(state));
        end

    maint_flag_follows_state: assert property (@(posedge clk) disable iff (!rst_n)
        maintenance_mode == is_maint_screen($past(state)))
        else begin
            errors++;
            $display("ERR maintenance_mode: got %h state %h",
                     $sampled(maintenance_mode), $sampled(state));
        end

    check_pulse_on_return: assert property (@(posedge clk) disable iff (!rst_n)
        manual_check_requested |->
            (state == ST_MAINT_OPTIONS && $past(state) == ST_MAINT_MANUAL_CHECK))
        else begin
            errors++;
            $display("ERR manual_check_requested: got %h state %h",
                     $sampled(manual_check_requested), $sampled(state));
        end

    // Pulse counters and insufficient dwell sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if (start_brewing_cmd) start_pulses++;
            if (manual_check_requested) check_pulses++;
            if (state == ST_CHECK_ERRORS) seen_check = 1'b1;
            if (state == ST_INSUFFICIENT) begin
                insuf_run++;
            end else if (insuf_run != 0) begin
                insuf_dwell = insuf_run;
                insuf_run   = 0;
            end
        end
    end

    //============================================================
    // Scenario sequence
    //============================================================
    initial begin
        seed = 32'h4b56;
        errors = 0;
        checks = 0;
        start_pulses = 0;
        check_pulses = 0;
        insuf_run = 0;
        insuf_dwell = 0;
        seen_check = 1'b0;
        clk = 1'b0;
        rst_n = 1'b0;
        btn = '0;
        error_present = 1'b0;
        error_count = 4'd0;
        warning_count = 4'd0;
        pressure_ready = 1'b1;
        can_make_coffee = 1'b1;
        recipe_valid = 1'b1;
        brewing_active = 1'b0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // Reset values
        expect_eq("state", 32'(state), 32'(ST_SPLASH));
        expect_eq("start_brewing_cmd", 32'(start_brewing_cmd), 0);
        expect_eq("maintenance_mode", 32'(maintenance_mode), 0);
        expect_eq("manual_check_requested", 32'(manual_check_requested), 0);
        expect_eq("display_refresh", 32'(display_refresh), 0);
        expect_eq("coffee_bin", 32'(coffee_bin), 0);
        expect_eq("drink", 32'(drink), 32'(DRINK_BLACK));
        expect_eq("size", 32'(size), 32'(SIZE_12OZ));
        expect_eq("maint_option", 32'(maint_option), 32'(MAINT_VIEW_ERRORS));

        // Clean brew flow where check_errors passes on its own
        press_button(BTN_SELECT);
        wait_state(ST_COFFEE_SELECT, STATE_LIMIT);
        expect_eq("seen check_errors", 32'(seen_check), 1);
        press_button(BTN_LEFT);
        expect_eq("coffee_bin", 32'(coffee_bin), 1);
        press_button(BTN_SELECT);
        wait_state(ST_DRINK_SELECT, STATE_LIMIT);
        exp_drink = 0;
        repeat (NUM_DRINKS) begin
            press_button(BTN_RIGHT);
            exp_drink = (exp_drink + 1) % NUM_DRINKS;
            expect_eq("drink", 32'(drink), exp_drink);
        end
        press_button(BTN_SELECT);
        press_button(BTN_SELECT);
        wait_state(ST_CONFIRM, STATE_LIMIT);
        pulses_before = start_pulses;
        press_button(BTN_SELECT);
        wait_state(ST_BREWING, STATE_LIMIT);
        expect_eq("start pulses", 32'(start_pulses), 32'(pulses_before + 1));
        brewing_active = 1'b1;
        repeat (3) @(negedge clk);
        brewing_active = 1'b0;
        wait_state(ST_COMPLETE, STATE_LIMIT);
        press_button(BTN_RIGHT);
        wait_state(ST_SPLASH, STATE_LIMIT);

        // Insufficient screen with timeout then early cancel
        recipe_valid = 1'b0;
        walk_to_confirm();
        press_button(BTN_SELECT);
        wait_state(ST_CONFIRM, INSUF_TO + STATE_LIMIT);
        @(negedge clk);
        expect_eq("insufficient dwell", 32'(insuf_dwell), INSUF_TO);
        press_button(BTN_SELECT);
        press_button(BTN_CANCEL);
        wait_state(ST_CONFIRM, STATE_LIMIT);
        @(negedge clk);
        expect_eq("early cancel", 32'(insuf_dwell < INSUF_TO), 1);

        // Abort during brewing without restarting the brew
        recipe_valid = 1'b1;
        pulses_before = start_pulses;
        press_button(BTN_SELECT);
        wait_state(ST_BREWING, STATE_LIMIT);
        press_button(BTN_CANCEL);
        wait_state(ST_ABORT_CONFIRM, STATE_LIMIT);
        press_button(BTN_CANCEL);
        wait_state(ST_BREWING, STATE_LIMIT);
        press_button(BTN_CANCEL);
        wait_state(ST_ABORT_CONFIRM, STATE_LIMIT);
        press_button(BTN_SELECT);
        wait_state(ST_SPLASH, STATE_LIMIT);
        expect_eq("start pulses", 32'(start_pulses), 32'(pulses_before + 1));

        // Hidden maintenance menu
        hold_combo(BTN_LEFT);
        wait_state(ST_MAINT_OPTIONS, STATE_LIMIT);
        expect_eq("maint_option", 32'(maint_option), 32'(MAINT_VIEW_ERRORS));
        press_button(BTN_RIGHT);
        expect_eq("maint_option", 32'(maint_option), 32'(MAINT_MANUAL_CHECK));
        press_button(BTN_SELECT);
        wait_state(ST_MAINT_MANUAL_CHECK, STATE_LIMIT);
        pulses_before = check_pulses;
        press_button(BTN_SELECT);
        wait_state(ST_MAINT_OPTIONS, STATE_LIMIT);
        expect_eq("manual check pulses", 32'(check_pulses), 32'(pulses_before + 1));
        press_button(BTN_RIGHT);
        press_button(BTN_RIGHT);
        expect_eq("maint_option", 32'(maint_option), 32'(MAINT_EXIT));
        press_button(BTN_SELECT);
        wait_state(ST_SPLASH, STATE_LIMIT);
        expect_eq("maintenance_mode", 32'(maintenance_mode), 0);

        // Critical errors block while warnings wait for select
        warning_count = 4'd2;
        press_button(BTN_SELECT);
        wait_state(ST_CHECK_ERRORS, STATE_LIMIT);
        error_present = 1'b1;
        error_count = 4'd3;
        press_button(BTN_SELECT);
        expect_eq("state", 32'(state), 32'(ST_CHECK_ERRORS));
        error_present = 1'b0;
        error_count = 4'd0;
        repeat (SETTLE_CYCLES) @(negedge clk);
        expect_eq("state", 32'(state), 32'(ST_CHECK_ERRORS));
        press_button(BTN_SELECT);
        wait_state(ST_COFFEE_SELECT, STATE_LIMIT);
        warning_count = 4'd0;
        press_button(BTN_CANCEL);
        wait_state(ST_SPLASH, STATE_LIMIT);

        $display("Checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+bench
rtl/menu_pkg.sv
rtl/button_event_if.sv
rtl/debounce_filter.sv
rtl/button_events.sv
rtl/selection_cursors.sv
rtl/menu_fsm.sv
rtl/menu_navigator.sv
bench/tb_menu_navigator.sv

//--- Makefile
TOP := tb_menu_navigator

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | awk '{ print } /^TEST PASSED$$/ { ok = 1 } END { exit !ok }'

lint:
	verilator --lint-only -Wall --timing --assert -f verilog.f --top-module menu_navigator

clean:
	rm -rf obj_dir
